//--- hdl/cache_pkg.sv
// cache geometry constants, controller state enum and line type
package cache_pkg;

  // ways per set
  localparam int NUM_WAYS = 2;

  // byte offset bits inside a 16-byte line
  localparam int OFFSET_W = 4;

  // one line holds two 64-bit words
  localparam int LINE_W = 128;

  // controller states
  // ST_IDLE    accepting a fetch while the tag compare runs on the incoming address
  // ST_LOOKUP  word registered after the ram read and held until taken
  // ST_REQ     line address waiting on the read bus
  // ST_FILL    collecting burst beats into the chosen way
  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_LOOKUP = 2'd1,
    ST_REQ    = 2'd2,
    ST_FILL   = 2'd3
  } cache_state_e;

  // full cache line, low word at the line base address
  typedef logic [LINE_W-1:0] line_t;

endpackage

//--- hdl/bus_pkg.sv
// read bus data width, burst length, beat counter type and response codes
package bus_pkg;

  // width of one beat
  localparam int DATA_W = 64;

  // beats per line fill
  localparam int BURST_BEATS = 2;

  localparam int BEAT_W = $clog2(BURST_BEATS);

  typedef logic [BEAT_W-1:0] beat_cnt_t;  // beat number inside a burst

  // slave response per beat
  typedef enum logic [1:0] {
    RESP_OKAY = 2'b00,
    RESP_ERR  = 2'b10
  } bus_resp_e;

endpackage

//--- hdl/mem_rd_if.sv
// burst read bus interface with master and slave modports
`timescale 1ns/1ps

interface mem_rd_if #(
  parameter int ADDR_W = 32
);

  // address channel
  logic                       ar_valid;
  logic                       ar_ready;
  logic [ADDR_W-1:0]          ar_addr;   // line base address

  // read data channel
  logic                       r_valid;
  logic                       r_ready;
  logic [bus_pkg::DATA_W-1:0] r_data;
  logic                       r_last;    // final beat of the burst
  bus_pkg::bus_resp_e         r_resp;

  modport master (
    output ar_valid, ar_addr, r_ready,
    input  ar_ready, r_valid, r_data, r_last, r_resp
  );

  modport slave (
    input  ar_valid, ar_addr, r_ready,
    output ar_ready, r_valid, r_data, r_last, r_resp
  );

endinterface

//--- hdl/cache_way_ram.sv
// data array for one cache way, synchronous read, per-half write enables
`timescale 1ns/1ps

module cache_way_ram #(
  parameter int INDEX_W = 6
) (
  input  logic                       clk,
  input  logic                       we_lo_i,  // beat 0 of the line
  input  logic                       we_hi_i,  // beat 1 of the line
  input  logic [INDEX_W-1:0]         addr_i,
  input  logic [bus_pkg::DATA_W-1:0] wdata_i,
  output cache_pkg::line_t           rdata_o
);

  localparam int DEPTH = 2 ** INDEX_W;

  cache_pkg::line_t mem_q [DEPTH];

  always_ff @(posedge clk) begin
    if (we_lo_i) begin
      mem_q[addr_i][bus_pkg::DATA_W-1:0] <= wdata_i;
    end
    if (we_hi_i) begin
      mem_q[addr_i][cache_pkg::LINE_W-1:bus_pkg::DATA_W] <= wdata_i;
    end
    // old contents on a same-edge write
    rdata_o <= mem_q[addr_i];
  end

endmodule

//--- hdl/icache.sv
// read-only instruction cache controller with tag, valid and victim arrays and line fill
`timescale 1ns/1ps

module icache #(
  parameter int ADDR_W  = 32,
  parameter int INDEX_W = 6
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  input  logic [ADDR_W-1:0]          req_addr_i,
  output logic                       rsp_valid_o,
  input  logic                       rsp_ready_i,
  output logic [bus_pkg::DATA_W-1:0] rsp_data_o,
  mem_rd_if.master                   mem
);

  localparam int TAG_W    = ADDR_W - INDEX_W - cache_pkg::OFFSET_W;
  localparam int SETS     = 2 ** INDEX_W;
  localparam int WAY_W    = $clog2(cache_pkg::NUM_WAYS);
  localparam int WORD_LSB = $clog2(bus_pkg::DATA_W / 8);  // byte bits inside a word

  cache_pkg::cache_state_e state_q;

  logic [ADDR_W-1:0]    addr_q;      // fetch address under service
  logic [WAY_W-1:0]     way_q;       // hit way or fill way
  bus_pkg::beat_cnt_t   beat_q;
  logic                 ar_valid_q;
  logic                 r_ready_q;

  // per-set bookkeeping
  logic [TAG_W-1:0]     tag_q    [cache_pkg::NUM_WAYS][SETS];
  logic [SETS-1:0]      valid_q  [cache_pkg::NUM_WAYS];
  logic [WAY_W-1:0]     victim_q [SETS];

  logic [TAG_W-1:0]     req_tag;
  logic [INDEX_W-1:0]   req_idx;
  logic [INDEX_W-1:0]   cur_idx;
  logic [INDEX_W-1:0]   ram_addr;
  bus_pkg::beat_cnt_t   word_sel;

  logic [cache_pkg::NUM_WAYS-1:0] hit_vec;
  logic [cache_pkg::NUM_WAYS-1:0] we_lo;
  logic [cache_pkg::NUM_WAYS-1:0] we_hi;
  logic [WAY_W-1:0]     hit_way;
  logic [WAY_W-1:0]     fill_way;
  logic                 any_invalid;
  logic                 hit;

  cache_pkg::line_t     way_rdata [cache_pkg::NUM_WAYS];

  logic req_fire;
  logic r_fire;

  // address fields
  assign req_tag  = req_addr_i[ADDR_W-1 -: TAG_W];
  assign req_idx  = req_addr_i[cache_pkg::OFFSET_W +: INDEX_W];
  assign cur_idx  = addr_q[cache_pkg::OFFSET_W +: INDEX_W];
  assign word_sel = addr_q[cache_pkg::OFFSET_W-1:WORD_LSB];  // which beat holds the word

  // ram follows the incoming index while idle so a hit reads in one edge
  assign ram_addr = (state_q == cache_pkg::ST_IDLE) ? req_idx : cur_idx;

  assign req_ready_o = (state_q == cache_pkg::ST_IDLE);
  assign req_fire    = req_valid_i && req_ready_o;
  assign r_fire      = mem.r_valid && r_ready_q;

  assign mem.ar_valid = ar_valid_q;
  assign mem.ar_addr  = {addr_q[ADDR_W-1:cache_pkg::OFFSET_W], {cache_pkg::OFFSET_W{1'b0}}};
  assign mem.r_ready  = r_ready_q;

  // tag compare and way choice for the incoming fetch
  always_comb begin
    hit_vec     = '0;
    hit_way     = '0;
    fill_way    = victim_q[req_idx];
    any_invalid = 1'b0;
    for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
      hit_vec[w] = valid_q[w][req_idx] && (tag_q[w][req_idx] == req_tag);
    end
    // downward scan so the lowest matching way wins
    for (int w = cache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
      if (hit_vec[w]) begin
        hit_way = WAY_W'(w);
      end
      if (!valid_q[w][req_idx]) begin
        fill_way    = WAY_W'(w);
        any_invalid = 1'b1;
      end
    end
  end

  assign hit = |hit_vec;

  for (genvar g = 0; g < cache_pkg::NUM_WAYS; g++) begin : g_way
    assign we_lo[g] = r_fire && (way_q == WAY_W'(g)) && (beat_q == '0);
    assign we_hi[g] = r_fire && (way_q == WAY_W'(g)) && (beat_q == '1);

    cache_way_ram #(
      .INDEX_W (INDEX_W)
    ) way_ram_inst (
      .clk     (clk),
      .we_lo_i (we_lo[g]),
      .we_hi_i (we_hi[g]),
      .addr_i  (ram_addr),
      .wdata_i (mem.r_data),
      .rdata_o (way_rdata[g])
    );
  end

  // control FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= cache_pkg::ST_IDLE;
      rsp_valid_o <= 1'b0;
      ar_valid_q  <= 1'b0;
      r_ready_q   <= 1'b0;
      beat_q      <= '0;
      for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
        valid_q[w] <= '0;
      end
      for (int s = 0; s < SETS; s++) begin
        victim_q[s] <= '0;
      end
    end else begin
      case (state_q)
        cache_pkg::ST_IDLE: begin
          if (req_fire) begin
            if (hit) begin
              state_q <= cache_pkg::ST_LOOKUP;
            end else begin
              state_q                    <= cache_pkg::ST_REQ;
              ar_valid_q                 <= 1'b1;
              valid_q[fill_way][req_idx] <= 1'b0;  // line is stale until the fill ends
              if (!any_invalid) begin
                victim_q[req_idx] <= victim_q[req_idx] + 1'b1;
              end
            end
          end
        end
        cache_pkg::ST_LOOKUP: begin
          if (!rsp_valid_o) begin
            rsp_valid_o <= 1'b1;
          end else if (rsp_ready_i) begin
            rsp_valid_o <= 1'b0;
            state_q     <= cache_pkg::ST_IDLE;
          end
        end
        cache_pkg::ST_REQ: begin
          if (mem.ar_ready) begin
            ar_valid_q <= 1'b0;
            r_ready_q  <= 1'b1;
            beat_q     <= '0;
            state_q    <= cache_pkg::ST_FILL;
          end
        end
        cache_pkg::ST_FILL: begin
          if (r_fire) begin
            beat_q <= beat_q + 1'b1;
            if (mem.r_last) begin
              r_ready_q               <= 1'b0;
              valid_q[way_q][cur_idx] <= 1'b1;
              rsp_valid_o             <= 1'b1;  // word already captured from the bus
              state_q                 <= cache_pkg::ST_LOOKUP;
            end
          end
        end
        default: state_q <= cache_pkg::ST_IDLE;
      endcase
    end
  end

  // fetch address, tags and response word
  always_ff @(posedge clk) begin
    if (req_fire) begin
      addr_q <= req_addr_i;
      way_q  <= hit ? hit_way : fill_way;
      if (!hit) begin
        tag_q[fill_way][req_idx] <= req_tag;
      end
    end
    if (state_q == cache_pkg::ST_LOOKUP && !rsp_valid_o) begin
      rsp_data_o <= way_rdata[way_q][word_sel * bus_pkg::DATA_W +: bus_pkg::DATA_W];
    end else if (r_fire && beat_q == word_sel) begin
      rsp_data_o <= mem.r_data;  // requested word straight off the bus
    end
  end

  a_no_ar_in_idle: assert property (@(posedge clk) disable iff (rst)
    state_q == cache_pkg::ST_IDLE |-> !mem.ar_valid);

  // response held under back-pressure
  a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_data_o));

  a_last_beat: assert property (@(posedge clk) disable iff (rst)
    mem.r_valid && mem.r_ready |->
      mem.r_last == (beat_q == bus_pkg::beat_cnt_t'(bus_pkg::BURST_BEATS - 1)));

endmodule

//--- hdl/mem_arbiter.sv
// round-robin arbiter for two burst read masters onto one bus
`timescale 1ns/1ps

module mem_arbiter #(
  parameter int ADDR_W = 32
) (
  input  logic      clk,
  input  logic      rst,
  mem_rd_if.slave   m0,
  mem_rd_if.slave   m1,
  mem_rd_if.master  bus
);

  logic              lock_q;   // grant frozen until the burst ends
  logic              grant_q;  // 0 = m0, 1 = m1
  logic              last_q;   // master served last
  logic              pick;
  logic              sel;
  logic              r_done;
  logic [ADDR_W-1:0] ar_addr_sel;

  // on a collision the master not served last wins
  always_comb begin
    if (m0.ar_valid && m1.ar_valid) begin
      pick = ~last_q;
    end else begin
      pick = m1.ar_valid;
    end
  end

  assign sel    = lock_q ? grant_q : pick;
  assign r_done = bus.r_valid && bus.r_ready && bus.r_last;

  always_ff @(posedge clk) begin
    if (rst) begin
      lock_q  <= 1'b0;
      grant_q <= 1'b0;
      last_q  <= 1'b1;  // m0 first on the first collision
    end else if (!lock_q) begin
      if (m0.ar_valid || m1.ar_valid) begin
        lock_q  <= 1'b1;
        grant_q <= pick;
        last_q  <= pick;
      end
    end else if (r_done) begin
      lock_q <= 1'b0;
    end
  end

  // address channel passes through without added cycles
  assign ar_addr_sel  = sel ? m1.ar_addr : m0.ar_addr;
  assign bus.ar_valid = sel ? m1.ar_valid : m0.ar_valid;
  assign bus.ar_addr  = ar_addr_sel;
  assign m0.ar_ready  = !sel && bus.ar_ready;
  assign m1.ar_ready  = sel && bus.ar_ready;

  // read data only reaches the granted master
  assign bus.r_ready = lock_q && (grant_q ? m1.r_ready : m0.r_ready);
  assign m0.r_valid  = lock_q && !grant_q && bus.r_valid;
  assign m1.r_valid  = lock_q && grant_q && bus.r_valid;
  assign m0.r_data   = bus.r_data;
  assign m1.r_data   = bus.r_data;
  assign m0.r_last   = bus.r_last;
  assign m1.r_last   = bus.r_last;
  assign m0.r_resp   = bus.r_resp;
  assign m1.r_resp   = bus.r_resp;

  // the locked master's line address stays on the bus until its burst ends
  a_grant_held: assert property (@(posedge clk) disable iff (rst)
    lock_q && !r_done |=> $stable(bus.ar_addr));

  // memory answers only a burst it accepted from a granted master
  a_r_granted: assert property (@(posedge clk) disable iff (rst)
    bus.r_valid |-> lock_q);

endmodule

//--- hdl/fetch_subsys_top.sv
// dual-port fetch subsystem top with two instruction caches and the read bus arbiter
`timescale 1ns/1ps

module fetch_subsys_top #(
  parameter int ADDR_W  = 32,
  parameter int INDEX_W = 6
) (
  input  logic                       clk,
  input  logic                       rst,
  // fetch port 0
  input  logic                       fetch0_req_valid_i,
  output logic                       fetch0_req_ready_o,
  input  logic [ADDR_W-1:0]          fetch0_req_addr_i,
  output logic                       fetch0_rsp_valid_o,
  input  logic                       fetch0_rsp_ready_i,
  output logic [bus_pkg::DATA_W-1:0] fetch0_rsp_data_o,
  // fetch port 1
  input  logic                       fetch1_req_valid_i,
  output logic                       fetch1_req_ready_o,
  input  logic [ADDR_W-1:0]          fetch1_req_addr_i,
  output logic                       fetch1_rsp_valid_o,
  input  logic                       fetch1_rsp_ready_i,
  output logic [bus_pkg::DATA_W-1:0] fetch1_rsp_data_o,
  // memory read bus
  output logic                       mem_ar_valid_o,
  input  logic                       mem_ar_ready_i,
  output logic [ADDR_W-1:0]          mem_ar_addr_o,
  input  logic                       mem_r_valid_i,
  output logic                       mem_r_ready_o,
  input  logic [bus_pkg::DATA_W-1:0] mem_r_data_i,
  input  logic                       mem_r_last_i
);

  mem_rd_if #(.ADDR_W(ADDR_W)) c0_bus ();
  mem_rd_if #(.ADDR_W(ADDR_W)) c1_bus ();
  mem_rd_if #(.ADDR_W(ADDR_W)) mem_bus ();

  icache #(
    .ADDR_W  (ADDR_W),
    .INDEX_W (INDEX_W)
  ) icache0_inst (
    .clk         (clk),
    .rst         (rst),
    .req_valid_i (fetch0_req_valid_i),
    .req_ready_o (fetch0_req_ready_o),
    .req_addr_i  (fetch0_req_addr_i),
    .rsp_valid_o (fetch0_rsp_valid_o),
    .rsp_ready_i (fetch0_rsp_ready_i),
    .rsp_data_o  (fetch0_rsp_data_o),
    .mem         (c0_bus.master)
  );

  icache #(
    .ADDR_W  (ADDR_W),
    .INDEX_W (INDEX_W)
  ) icache1_inst (
    .clk         (clk),
    .rst         (rst),
    .req_valid_i (fetch1_req_valid_i),
    .req_ready_o (fetch1_req_ready_o),
    .req_addr_i  (fetch1_req_addr_i),
    .rsp_valid_o (fetch1_rsp_valid_o),
    .rsp_ready_i (fetch1_rsp_ready_i),
    .rsp_data_o  (fetch1_rsp_data_o),
    .mem         (c1_bus.master)
  );

  mem_arbiter #(
    .ADDR_W (ADDR_W)
  ) mem_arbiter_inst (
    .clk (clk),
    .rst (rst),
    .m0  (c0_bus.slave),
    .m1  (c1_bus.slave),
    .bus (mem_bus.master)
  );

  // external bus breakout
  assign mem_ar_valid_o   = mem_bus.ar_valid;
  assign mem_ar_addr_o    = mem_bus.ar_addr;
  assign mem_r_ready_o    = mem_bus.r_ready;
  assign mem_bus.ar_ready = mem_ar_ready_i;
  assign mem_bus.r_valid  = mem_r_valid_i;
  assign mem_bus.r_data   = mem_r_data_i;
  assign mem_bus.r_last   = mem_r_last_i;
  assign mem_bus.r_resp   = bus_pkg::RESP_OKAY;  // no error path on this bus

endmodule

//--- verif/tb_fetch.sv
// testbench for the fetch subsystem with memory model, fetch drivers and checks
`timescale 1ns/1ps

module tb_fetch;

  localparam int PORT_BIT   = 20;    // address bit that marks port 1
  localparam int TIMEOUT    = 200;   // cycles for one wait
  localparam int IDLE_LIMIT = 5000;  // memory model idle wait

  logic        clk;
  logic        rst;
  logic        req_valid [2];
  logic        req_ready [2];
  logic [31:0] req_addr [2];
  logic        rsp_valid [2];
  logic        rsp_ready [2];
  logic [63:0] rsp_data [2];
  logic        mem_ar_valid;
  logic        mem_ar_ready;
  logic [31:0] mem_ar_addr;
  logic        mem_r_valid;
  logic        mem_r_ready;
  logic [63:0] mem_r_data;
  logic        mem_r_last;

  integer      seed;
  int          err_count;
  int          ar_count [2];      // ar handshakes per master
  logic [31:0] last_ar_addr [2];
  int          ar_order [$];      // master of each ar handshake

  fetch_subsys_top #(
    .ADDR_W  (32),
    .INDEX_W (6)
  ) fetch_subsys_top_inst (
    .clk                (clk),
    .rst                (rst),
    .fetch0_req_valid_i (req_valid[0]),
    .fetch0_req_ready_o (req_ready[0]),
    .fetch0_req_addr_i  (req_addr[0]),
    .fetch0_rsp_valid_o (rsp_valid[0]),
    .fetch0_rsp_ready_i (rsp_ready[0]),
    .fetch0_rsp_data_o  (rsp_data[0]),
    .fetch1_req_valid_i (req_valid[1]),
    .fetch1_req_ready_o (req_ready[1]),
    .fetch1_req_addr_i  (req_addr[1]),
    .fetch1_rsp_valid_o (rsp_valid[1]),
    .fetch1_rsp_ready_i (rsp_ready[1]),
    .fetch1_rsp_data_o  (rsp_data[1]),
    .mem_ar_valid_o     (mem_ar_valid),
    .mem_ar_ready_i     (mem_ar_ready),
    .mem_ar_addr_o      (mem_ar_addr),
    .mem_r_valid_i      (mem_r_valid),
    .mem_r_ready_o      (mem_r_ready),
    .mem_r_data_i       (mem_r_data),
    .mem_r_last_i       (mem_r_last)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // word address in the low half and its inverse in the high half
  function automatic logic [63:0] word_pattern(input logic [31:0] addr);
    logic [31:0] a;
    a = addr & ~32'h7;
    return {~a, a};
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    err_count++;
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
    end
  endtask

  // one fetch on one port checked against the file's miss flag
  task automatic run_fetch(input int port, input logic [31:0] addr, input bit miss,
                           input bit use_gap);
    int          gap;
    int          waited;
    int          edges;
    int          stalls;
    int          ar_before;
    bit          rdy;
    logic [63:0] held;
    string       pname;
    pname = $sformatf("fetch%0d", port);
    gap = use_gap ? ($unsigned($random(seed)) % 4) : 0;
    repeat (gap) @(negedge clk);
    req_valid[port] = 1'b1;
    req_addr[port]  = addr;
    rsp_ready[port] = 1'b1;
    waited = 0;
    while (!req_ready[port]) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT) begin
        abort_run($sformatf("%s request was never accepted", pname));
      end
    end
    ar_before = ar_count[port];
    @(negedge clk);  // request taken on the edge in between
    req_valid[port] = 1'b0;
    edges = 1;
    while (!rsp_valid[port]) begin
      @(negedge clk);
      edges++;
      if (edges > TIMEOUT) begin
        abort_run($sformatf("%s response never arrived", pname));
      end
    end
    if (!miss) begin
      check_value({pname, "_hit_latency"}, 64'(edges), 64'(2));
    end
    check_value({pname, "_rsp_data_o"}, rsp_data[port], word_pattern(addr));
    held = rsp_data[port];
    stalls = 0;
    do begin
      rdy = (stalls >= 6) || (($random(seed) & 3) != 0);  // mostly ready
      rsp_ready[port] = rdy;
      @(negedge clk);
      if (!rdy) begin
        stalls++;
        check_value({pname, "_rsp_valid_o"}, 64'(rsp_valid[port]), 64'(1));
        check_value({pname, "_rsp_data_o"}, rsp_data[port], held);
      end
    end while (!rdy);
    rsp_ready[port] = 1'b0;
    check_value({pname, "_ar_count"}, 64'(ar_count[port] - ar_before), 64'(miss));
    if (miss) begin
      check_value({pname, "_ar_addr"}, 64'(last_ar_addr[port]), 64'(addr & ~32'hF));
    end
  endtask

  // memory model serving one burst at a time
  initial begin : memory_model
    int          idle;
    int          gap;
    int          waited;
    int          master;
    logic [31:0] addr;
    mem_ar_ready = 1'b0;
    mem_r_valid  = 1'b0;
    mem_r_data   = '0;
    mem_r_last   = 1'b0;
    ar_count[0]  = 0;
    ar_count[1]  = 0;
    repeat (5) @(negedge clk);  // past reset
    forever begin
      idle = 0;
      while (!mem_ar_valid) begin
        @(negedge clk);
        idle++;
        if (idle > IDLE_LIMIT) begin
          abort_run("memory model saw no read request for too long");
        end
      end
      addr = mem_ar_addr;
      gap = $unsigned($random(seed)) % 4;
      repeat (gap) begin
        @(negedge clk);
        check_value("mem_ar_valid_o", 64'(mem_ar_valid), 64'(1));
        check_value("mem_ar_addr_o", 64'(mem_ar_addr), 64'(addr));
      end
      mem_ar_ready = 1'b1;
      @(negedge clk);  // address accepted on the edge in between
      mem_ar_ready = 1'b0;
      master = int'(addr[PORT_BIT]);
      ar_count[master]++;
      last_ar_addr[master] = addr;
      ar_order.push_back(master);
      for (int b = 0; b < 2; b++) begin
        gap = $unsigned($random(seed)) % 3;
        repeat (gap) @(negedge clk);
        check_value("mem_ar_valid_o", 64'(mem_ar_valid), 64'(0));  // no request mid-burst
        mem_r_valid = 1'b1;
        mem_r_data  = word_pattern(addr + 32'(8 * b));
        mem_r_last  = (b == 1);
        waited = 0;
        while (!mem_r_ready) begin
          @(negedge clk);
          waited++;
          if (waited > TIMEOUT) begin
            abort_run("read data beat was never accepted");
          end
        end
        @(negedge clk);
        mem_r_valid = 1'b0;
        mem_r_last  = 1'b0;
      end
    end
  end

  initial begin : main
    int          fd;
    string       text;
    int          port;
    int          miss;
    int          first;
    int          expect_first;
    logic [31:0] addr;
    logic [31:0] q_addr [$];
    int          q_port [$];
    bit          q_miss [$];
    int          lock0 [$];
    int          lock1 [$];
    seed      = 32'h7ace;
    err_count = 0;
    rst       = 1'b1;
    for (int p = 0; p < 2; p++) begin
      req_valid[p] = 1'b0;
      req_addr[p]  = '0;
      rsp_ready[p] = 1'b0;
    end
    fd = $fopen("verif/fetch_input.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open verif/fetch_input.txt");
    end
    while (!$feof(fd)) begin
      text = "";
      if ($fgets(text, fd) > 0 && text.len() > 1 && text.getc(0) != "#") begin
        if ($sscanf(text, "%d %h %d", port, addr, miss) != 3) begin
          abort_run($sformatf("malformed line in fetch list: %s", text));
        end
        if (addr[PORT_BIT] != port[0]) begin
          abort_run($sformatf("address %h does not belong to port %0d", addr, port));
        end
        if (port == 2) lock0.push_back(q_addr.size());
        if (port == 3) lock1.push_back(q_addr.size());
        q_addr.push_back(addr);
        q_port.push_back(port);
        q_miss.push_back(miss != 0);
      end
    end
    $fclose(fd);
    repeat (4) @(negedge clk);
    // reset state
    check_value("fetch0_req_ready_o", 64'(req_ready[0]), 64'(1));
    check_value("fetch1_req_ready_o", 64'(req_ready[1]), 64'(1));
    check_value("fetch0_rsp_valid_o", 64'(rsp_valid[0]), 64'(0));
    check_value("fetch1_rsp_valid_o", 64'(rsp_valid[1]), 64'(0));
    check_value("mem_ar_valid_o", 64'(mem_ar_valid), 64'(0));
    check_value("mem_r_ready_o", 64'(mem_r_ready), 64'(0));
    rst = 1'b0;
    @(negedge clk);
    fork
      begin
        foreach (q_addr[i]) begin
          if (q_port[i] == 0) run_fetch(0, q_addr[i], q_miss[i], 1'b1);
        end
      end
      begin
        foreach (q_addr[i]) begin
          if (q_port[i] == 1) run_fetch(1, q_addr[i], q_miss[i], 1'b1);
        end
      end
    join
    if (lock0.size() != lock1.size()) begin
      abort_run("lockstep entries of the two ports do not pair up");
    end
    // both ports start together, so two misses collide at the arbiter
    foreach (lock0[k]) begin
      first = ar_order.size();
      expect_first = (first == 0) ? 0 : 1 - ar_order[first - 1];
      fork
        run_fetch(0, q_addr[lock0[k]], q_miss[lock0[k]], 1'b0);
        run_fetch(1, q_addr[lock1[k]], q_miss[lock1[k]], 1'b0);
      join
      if (q_miss[lock0[k]] && q_miss[lock1[k]]) begin
        check_value("collision_first_master", 64'(ar_order[first]), 64'(expect_first));
        check_value("collision_second_master", 64'(ar_order[first + 1]),
                    64'(1 - expect_first));
      end
    end
    repeat (2) @(negedge clk);
    if (err_count == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("FAIL: see errors above");
      $fatal(1);
    end
  end

endmodule

//--- verif/fetch_input.txt
# port addr(hex) miss: ports 0 and 1 run concurrently, 2 and 3 are ports 0 and 1 in lockstep pairs
# address bit 20 marks port 1, miss is 1 where the fetch has to fill a line
0 00000100 1
0 00000108 0
0 00000500 1
0 00000104 0
0 0000050c 0
0 00000900 1
0 00000508 0
0 00000100 1
0 00000908 0
0 00000500 1
0 00000200 1
0 00000208 0
0 00000108 0
0 00000ff8 1
1 00100040 1
1 00100048 0
1 00100440 1
1 00100840 1
1 00100448 0
1 00100040 1
1 00100848 0
1 00100044 0
1 001003f0 1
2 00001000 1
3 00101000 1
2 00001010 1
3 00101010 1
2 00001008 0
3 00101018 0

//--- files.f
hdl/cache_pkg.sv
hdl/bus_pkg.sv
hdl/mem_rd_if.sv
hdl/cache_way_ram.sv
hdl/icache.sv
hdl/mem_arbiter.sv
hdl/fetch_subsys_top.sv
verif/tb_fetch.sv

//--- run.sh
#!/bin/sh
# build and run the fetch subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_fetch -f files.f -o tb_fetch_sim \
  && ./obj_dir/tb_fetch_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^PASS: all tests$" sim.log 2>/dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
